/* logic/pad_dma_pkg.sv */
// Shared widths and bus types for the mirror-padding DMA engine
// The AXI structs carry only the fields the engine drives or samples

`default_nettype none

package pad_dma_pkg;

    parameter int ADDR_W  = 32;  // Byte address
    parameter int DATA_W  = 32;  // One matrix element per beat
    parameter int WIDTH_W = 6;   // Matrix width N, 1 to 63
    parameter int LEN_W   = 8;   // AXI4 burst length field

    // Job description written by software
    typedef struct packed {
        logic [ADDR_W-1:0]  src_addr;
        logic [ADDR_W-1:0]  dst_addr;
        logic [WIDTH_W-1:0] mat_width;
    } dma_cfg_t;

    // Read address channel
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;   // Beats minus one
    } axi_ar_t;

    // Write address channel
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;   // Beats minus one
    } axi_aw_t;

    // Read data channel
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } axi_r_t;

    // Write data channel, all byte lanes enabled
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } axi_w_t;

    // Write response channel
    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

endpackage

`default_nettype wire

/* logic/pad_word_fifo.sv */
// Show-ahead word FIFO between the row reader and the row writer
// The oldest word sits on head_o; a pop retires it at the same edge

`timescale 1ns/1ps
`default_nettype none

module pad_word_fifo #(
    parameter int DEPTH  = 16,
    parameter int DATA_W = 32
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 push_i,
    input  wire  [DATA_W-1:0]   push_data_i,
    output logic                full_o,
    input  wire                 pop_i,
    output logic [DATA_W-1:0]   head_o,
    output logic                empty_o
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;     // Words held
    logic              do_push;
    logic              do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign full_o  = (count == CNT_W'(DEPTH));
    assign empty_o = (count == '0);
    assign head_o  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop_i |-> !empty_o);

endmodule

`default_nettype wire

/* logic/pad_row_reader.sv */
// Source row reader of the padding DMA
// Fetches rows 1, 1, 2 .. N, N as N-beat bursts and pushes every beat
// into the word FIFO, stalling R while the FIFO is full

`timescale 1ns/1ps
`default_nettype none

module pad_row_reader (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               launch_i,
    input  wire pad_dma_pkg::dma_cfg_t        job_i,
    output pad_dma_pkg::axi_ar_t              ar_o,
    output logic                              arvalid_o,
    input  wire                               arready_i,
    input  wire pad_dma_pkg::axi_r_t          r_i,
    input  wire                               rvalid_i,
    output logic                              rready_o,
    output logic                              push_o,
    output logic [pad_dma_pkg::DATA_W-1:0]    push_data_o,
    input  wire                               full_i
);
    import pad_dma_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_AR,
        S_R
    } state_t;

    state_t               state;
    logic [ADDR_W-1:0]    src_addr;
    logic [WIDTH_W-1:0]   mat_width;
    logic [WIDTH_W:0]     out_row;    // Output row, 0 to N+1
    logic [WIDTH_W-1:0]   src_row;    // Clamped to 1..N
    logic [2*WIDTH_W-1:0] row_words;
    logic                 last_row;
    logic                 r_fire;

    // Border rows reuse the nearest edge row
    always_comb begin
        if (out_row == '0) begin
            src_row = WIDTH_W'(1);
        end else if (out_row > {1'b0, mat_width}) begin
            src_row = mat_width;
        end else begin
            src_row = out_row[WIDTH_W-1:0];
        end
    end

    assign row_words = (src_row - 1'b1) * mat_width;
    assign last_row  = (out_row == {1'b0, mat_width} + 1'b1);

    always_comb begin
        ar_o.addr = src_addr + ADDR_W'({row_words, 2'b00});
        ar_o.len  = LEN_W'(mat_width - 1'b1);
    end

    assign arvalid_o   = (state == S_AR);
    assign rready_o    = (state == S_R) && !full_i;   // Back-pressure from FIFO
    assign r_fire      = rvalid_i && rready_o;
    assign push_o      = r_fire;
    assign push_data_o = r_i.data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            out_row <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (launch_i) begin
                        out_row <= '0;
                        state   <= S_AR;
                    end
                end
                S_AR: begin
                    if (arready_i) begin
                        state <= S_R;
                    end
                end
                S_R: begin
                    if (r_fire && r_i.last) begin
                        if (last_row) begin
                            state <= S_IDLE;   // Bottom border row fetched
                        end else begin
                            out_row <= out_row + 1'b1;
                            state   <= S_AR;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Job fields held for the whole read stream
    always_ff @(posedge clk) begin
        if (launch_i) begin
            src_addr  <= job_i.src_addr;
            mat_width <= job_i.mat_width;
        end
    end

    a_width_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        launch_i |-> job_i.mat_width != '0);

    // The writer only launches once the previous read stream has drained
    a_launch_idle: assert property (@(posedge clk) disable iff (!rst_n)
        launch_i |-> state == S_IDLE);

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        push_o |-> !full_i);

endmodule

`default_nettype wire

/* logic/pad_row_writer.sv */
// Padded row writer and job owner of the padding DMA
// Accepts the job, launches the reader and writes each output row as one
// N+2 beat burst, repeating the first and last column of the source row

`timescale 1ns/1ps
`default_nettype none

module pad_row_writer (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire pad_dma_pkg::dma_cfg_t        cfg_i,
    input  wire                               start_i,
    output logic                              done_o,
    output logic                              launch_o,
    output pad_dma_pkg::dma_cfg_t             job_o,
    output logic                              pop_o,
    input  wire  [pad_dma_pkg::DATA_W-1:0]    head_i,
    input  wire                               empty_i,
    output pad_dma_pkg::axi_aw_t              aw_o,
    output logic                              awvalid_o,
    input  wire                               awready_i,
    output pad_dma_pkg::axi_w_t               w_o,
    output logic                              wvalid_o,
    input  wire                               wready_i,
    input  wire pad_dma_pkg::axi_b_t          b_i,
    input  wire                               bvalid_i,
    output logic                              bready_o
);
    import pad_dma_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_AW,
        S_W,
        S_B
    } state_t;

    state_t                 state;
    dma_cfg_t               cfg_q;
    logic [WIDTH_W:0]       row;        // Output row, 0 to N+1
    logic [WIDTH_W:0]       col;        // Output column, 0 to N+1
    logic [WIDTH_W:0]       last_idx;   // N+1
    logic [2*WIDTH_W+1:0]   row_words;
    logic [DATA_W-1:0]      last_word;  // Source column N of this row
    logic                   tail_col;
    logic                   w_fire;

    assign last_idx  = {1'b0, cfg_q.mat_width} + 1'b1;
    assign row_words = row * (last_idx + 1'b1);
    assign tail_col  = (col == last_idx);

    always_comb begin
        aw_o.addr = cfg_q.dst_addr + ADDR_W'({row_words, 2'b00});
        aw_o.len  = LEN_W'(last_idx);
        w_o.data  = tail_col ? last_word : head_i;
        w_o.last  = tail_col;
    end

    assign awvalid_o = (state == S_AW);
    assign wvalid_o  = (state == S_W) && (tail_col || !empty_i);
    assign w_fire    = wvalid_o && wready_i;
    assign pop_o     = w_fire && (col != '0) && !tail_col;   // Column 0 only peeks
    assign bready_o  = (state == S_B);
    assign job_o     = cfg_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            done_o   <= 1'b1;
            launch_o <= 1'b0;
            row      <= '0;
            col      <= '0;
        end else begin
            launch_o <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start_i) begin
                        done_o   <= 1'b0;
                        launch_o <= 1'b1;
                        row      <= '0;
                        col      <= '0;
                        state    <= S_AW;
                    end
                end
                S_AW: begin
                    if (awready_i) begin
                        state <= S_W;
                    end
                end
                S_W: begin
                    if (w_fire) begin
                        if (tail_col) begin
                            col   <= '0;
                            state <= S_B;
                        end else begin
                            col <= col + 1'b1;
                        end
                    end
                end
                S_B: begin
                    // Response code is not checked
                    if (bvalid_i) begin
                        if (row == last_idx) begin
                            done_o <= 1'b1;
                            state  <= S_IDLE;
                        end else begin
                            row   <= row + 1'b1;
                            state <= S_AW;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && start_i) begin
            cfg_q <= cfg_i;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            last_word <= head_i;   // Replayed as the right border
        end
    end

    a_w_after_aw: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_o |-> !awvalid_o);

endmodule

`default_nettype wire

/* logic/pad_dma_top.sv */
// Mirror-padding DMA engine top level
// Row reader feeds the word FIFO, the row writer drains it to the AXI write port

`timescale 1ns/1ps
`default_nettype none

module pad_dma_top #(
    parameter int FIFO_DEPTH = 16,
    parameter int DATA_W     = pad_dma_pkg::DATA_W
) (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire pad_dma_pkg::dma_cfg_t    cfg_i,
    input  wire                           start_i,
    output logic                          done_o,
    output pad_dma_pkg::axi_ar_t          ar_o,
    output logic                          arvalid_o,
    input  wire                           arready_i,
    input  wire pad_dma_pkg::axi_r_t      r_i,
    input  wire                           rvalid_i,
    output logic                          rready_o,
    output pad_dma_pkg::axi_aw_t          aw_o,
    output logic                          awvalid_o,
    input  wire                           awready_i,
    output pad_dma_pkg::axi_w_t           w_o,
    output logic                          wvalid_o,
    input  wire                           wready_i,
    input  wire pad_dma_pkg::axi_b_t      b_i,
    input  wire                           bvalid_i,
    output logic                          bready_o
);
    import pad_dma_pkg::*;

    logic              launch;
    dma_cfg_t          job;
    logic              push;
    logic [DATA_W-1:0] push_data;
    logic              full;
    logic              pop;
    logic [DATA_W-1:0] head;
    logic              empty;

    pad_row_reader u_reader (
        .clk         (clk),
        .rst_n       (rst_n),
        .launch_i    (launch),
        .job_i       (job),
        .ar_o        (ar_o),
        .arvalid_o   (arvalid_o),
        .arready_i   (arready_i),
        .r_i         (r_i),
        .rvalid_i    (rvalid_i),
        .rready_o    (rready_o),
        .push_o      (push),
        .push_data_o (push_data),
        .full_i      (full)
    );

    pad_word_fifo #(
        .DEPTH  (FIFO_DEPTH),
        .DATA_W (DATA_W)
    ) u_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (push),
        .push_data_i (push_data),
        .full_o      (full),
        .pop_i       (pop),
        .head_o      (head),
        .empty_o     (empty)
    );

    pad_row_writer u_writer (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_i     (cfg_i),
        .start_i   (start_i),
        .done_o    (done_o),
        .launch_o  (launch),
        .job_o     (job),
        .pop_o     (pop),
        .head_i    (head),
        .empty_i   (empty),
        .aw_o      (aw_o),
        .awvalid_o (awvalid_o),
        .awready_i (awready_i),
        .w_o       (w_o),
        .wvalid_o  (wvalid_o),
        .wready_i  (wready_i),
        .b_i       (b_i),
        .bvalid_i  (bvalid_i),
        .bready_o  (bready_o)
    );

endmodule

`default_nettype wire

/* test/axi_mem_model.sv */
// AXI4 slave memory for the padding DMA testbench
// Word-keyed store with random 0 to 3 cycle stalls on every handshake,
// and a log of each AR, AW and W burst for the burst checks

`timescale 1ns/1ps
`default_nettype none

module axi_mem_model (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire pad_dma_pkg::axi_ar_t    ar_i,
    input  wire                          arvalid_i,
    output logic                         arready_o,
    output pad_dma_pkg::axi_r_t          r_o,
    output logic                         rvalid_o,
    input  wire                          rready_i,
    input  wire pad_dma_pkg::axi_aw_t    aw_i,
    input  wire                          awvalid_i,
    output logic                         awready_o,
    input  wire pad_dma_pkg::axi_w_t     w_i,
    input  wire                          wvalid_i,
    output logic                         wready_o,
    output pad_dma_pkg::axi_b_t          b_o,
    output logic                         bvalid_o,
    input  wire                          bready_i
);
    import pad_dma_pkg::*;

    logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];   // Keyed by word address
    axi_ar_t           ar_log [$];
    axi_aw_t           aw_log [$];
    int                w_beats_log [$];             // Beat number that carried last

    function automatic void write_word(input logic [ADDR_W-1:0] addr,
                                       input logic [DATA_W-1:0] data);
        mem[addr >> 2] = data;
    endfunction

    function automatic logic [DATA_W-1:0] read_word(input logic [ADDR_W-1:0] addr);
        if (mem.exists(addr >> 2)) begin
            return mem[addr >> 2];
        end
        return 'x;   // Never written
    endfunction

    function automatic void clear_logs();
        ar_log.delete();
        aw_log.delete();
        w_beats_log.delete();
    endfunction

    // Entered and left 2 ns after a rising edge
    task automatic stall();
        int cycles;
        cycles = $urandom_range(0, 3);
        repeat (cycles) begin
            @(posedge clk);
            #2;
        end
    endtask

    // Read port, one burst at a time
    initial begin : read_side
        axi_ar_t req;
        int      beat;
        arready_o = 1'b0;
        rvalid_o  = 1'b0;
        r_o       = '0;
        forever begin
            @(posedge clk);
            if (rst_n && arvalid_i) begin
                #2;
                stall();
                arready_o = 1'b1;
                @(posedge clk);            // Address is held, so it transfers here
                req = ar_i;
                ar_log.push_back(req);
                #2;
                arready_o = 1'b0;
                for (beat = 0; beat <= int'(req.len); beat++) begin
                    stall();
                    r_o.data = read_word(req.addr + ADDR_W'(4 * beat));
                    r_o.resp = 2'b00;
                    r_o.last = (beat == int'(req.len));
                    rvalid_o = 1'b1;
                    @(posedge clk);
                    while (!rready_i) @(posedge clk);
                    #2;
                    rvalid_o = 1'b0;
                end
            end
        end
    end

    // Write port: address, data beats until last, then the response
    initial begin : write_side
        axi_aw_t req;
        int      beat;
        logic    got_last;
        awready_o = 1'b0;
        wready_o  = 1'b0;
        bvalid_o  = 1'b0;
        b_o       = '0;
        forever begin
            @(posedge clk);
            if (rst_n && awvalid_i) begin
                #2;
                stall();
                awready_o = 1'b1;
                @(posedge clk);
                req = aw_i;
                aw_log.push_back(req);
                #2;
                awready_o = 1'b0;
                beat      = 0;
                got_last  = 1'b0;
                while (!got_last) begin
                    stall();
                    wready_o = 1'b1;
                    @(posedge clk);
                    while (!wvalid_i) @(posedge clk);
                    write_word(req.addr + ADDR_W'(4 * beat), w_i.data);
                    got_last = w_i.last;
                    beat++;
                    #2;
                    wready_o = 1'b0;
                end
                w_beats_log.push_back(beat);
                stall();
                b_o.resp = 2'b00;   // OKAY
                bvalid_o = 1'b1;
                @(posedge clk);
                while (!bready_i) @(posedge clk);
                #2;
                bvalid_o = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* test/pad_dma_tb.sv */
// Testbench for the mirror-padding DMA engine
// Random jobs through an AXI memory model, checked against a padding model

`timescale 1ns/1ps
`default_nettype none

module pad_dma_tb;
    import pad_dma_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_TESTS  = 14;   // 1x1, twelve random, busy start
    localparam int GUARD      = 4;    // Sentinel words on each side of the destination

    logic        clk;
    logic        rst_n;
    dma_cfg_t    cfg;
    logic        start;
    logic        done;
    axi_ar_t     ar;
    logic        arvalid;
    logic        arready;
    axi_r_t      r;
    logic        rvalid;
    logic        rready;
    axi_aw_t     aw;
    logic        awvalid;
    logic        awready;
    axi_w_t      w;
    logic        wvalid;
    logic        wready;
    axi_b_t      b;
    logic        bvalid;
    logic        bready;

    int          widths [NUM_TESTS];
    int          errors;
    int          failed_tests;
    int          limit_cycles;
    logic        limit_set;
    logic [31:0] src_q [$];           // Source words of the running job

    pad_dma_top #(.FIFO_DEPTH(16), .DATA_W(DATA_W)) u_dut (
        .clk(clk), .rst_n(rst_n), .cfg_i(cfg), .start_i(start), .done_o(done),
        .ar_o(ar), .arvalid_o(arvalid), .arready_i(arready),
        .r_i(r), .rvalid_i(rvalid), .rready_o(rready),
        .aw_o(aw), .awvalid_o(awvalid), .awready_i(awready),
        .w_o(w), .wvalid_o(wvalid), .wready_i(wready),
        .b_i(b), .bvalid_i(bvalid), .bready_o(bready)
    );

    axi_mem_model u_mem (
        .clk(clk), .rst_n(rst_n),
        .ar_i(ar), .arvalid_i(arvalid), .arready_o(arready),
        .r_o(r), .rvalid_o(rvalid), .rready_i(rready),
        .aw_i(aw), .awvalid_i(awvalid), .awready_o(awready),
        .w_i(w), .wvalid_i(wvalid), .wready_o(wready),
        .b_o(b), .bvalid_o(bvalid), .bready_i(bready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        wait (limit_set);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: the jobs did not finish within %0d cycles", limit_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    function automatic int clamp(input int idx, input int n);
        if (idx < 1) return 1;
        if (idx > n) return n;
        return idx;
    endfunction

    function automatic logic [31:0] guard_word(input logic [31:0] addr);
        return ~addr ^ 32'h5A5A_0000;
    endfunction

    function automatic dma_cfg_t random_cfg(input int n);
        dma_cfg_t c;
        c.src_addr  = 32'h1000_0000 + 32'($urandom_range(0, 65535) * 4);
        c.dst_addr  = 32'h2000_0000 + 32'($urandom_range(0, 65535) * 4);
        c.mat_width = WIDTH_W'(n);
        return c;
    endfunction

    // Destination and its guard ring all hold sentinels before a job
    task automatic poison_region(input logic [31:0] dst, input int n);
        int          i;
        logic [31:0] a;
        for (i = -GUARD; i < (n + 2) * (n + 2) + GUARD; i++) begin
            a = dst + 32'(4 * i);
            u_mem.write_word(a, guard_word(a));
        end
    endtask

    task automatic check_untouched(input logic [31:0] dst, input int first, input int last);
        int          i;
        logic [31:0] a;
        for (i = first; i <= last; i++) begin
            a = dst + 32'(4 * i);
            check_value($sformatf("sentinel @%h", a), u_mem.read_word(a), guard_word(a));
        end
    endtask

    task automatic load_job(input dma_cfg_t c);
        int i;
        int n;
        n = int'(c.mat_width);
        src_q.delete();
        for (i = 0; i < n * n; i++) begin
            src_q.push_back($urandom);
            u_mem.write_word(c.src_addr + 32'(4 * i), src_q[i]);
        end
        poison_region(c.dst_addr, n);
        u_mem.clear_logs();
    endtask

    task automatic check_result(input dma_cfg_t c);
        int          n;
        int          row;
        int          col;
        int          last;
        logic [31:0] a;
        axi_ar_t     ar_rec;
        axi_aw_t     aw_rec;
        n    = int'(c.mat_width);
        last = (n + 2) * (n + 2) - 1;
        for (row = 0; row < n + 2; row++) begin
            for (col = 0; col < n + 2; col++) begin
                a = c.dst_addr + 32'(4 * (row * (n + 2) + col));
                check_value($sformatf("dst[%0d][%0d]", row, col), u_mem.read_word(a),
                            src_q[(clamp(row, n) - 1) * n + clamp(col, n) - 1]);
            end
        end
        check_untouched(c.dst_addr, -GUARD, -1);
        check_untouched(c.dst_addr, last + 1, last + GUARD);
        check_value("ar bursts", u_mem.ar_log.size(), n + 2);
        check_value("aw bursts", u_mem.aw_log.size(), n + 2);
        for (row = 0; row < n + 2 && row < u_mem.ar_log.size(); row++) begin
            ar_rec = u_mem.ar_log[row];
            check_value($sformatf("ar[%0d].addr", row), ar_rec.addr,
                        c.src_addr + 32'((clamp(row, n) - 1) * n * 4));
            check_value($sformatf("ar[%0d].len", row), ar_rec.len, n - 1);
        end
        for (row = 0; row < n + 2 && row < u_mem.aw_log.size(); row++) begin
            aw_rec = u_mem.aw_log[row];
            check_value($sformatf("aw[%0d].addr", row), aw_rec.addr,
                        c.dst_addr + 32'(row * (n + 2) * 4));
            check_value($sformatf("aw[%0d].len", row), aw_rec.len, n + 1);
            check_value($sformatf("w[%0d] last beat", row), u_mem.w_beats_log[row], n + 2);
        end
    endtask

    task automatic run_job(input int id, input int n, input bit busy_start);
        dma_cfg_t c;
        dma_cfg_t other;
        int       errors_before;
        errors_before = errors;
        c = random_cfg(n);
        load_job(c);
        other = random_cfg((n == 8) ? 3 : n + 1);
        other.dst_addr = c.dst_addr + 32'h1000;   // Clear of the real destination
        if (busy_start) poison_region(other.dst_addr, int'(other.mat_width));
        @(posedge clk);
        #2;
        cfg   = c;
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        if (busy_start) begin
            repeat (4) @(posedge clk);
            check_value("done_o", done, 1'b0);
            #2;
            cfg   = other;
            start = 1'b1;
            @(posedge clk);
            #2;
            start = 1'b0;
        end
        @(posedge clk);
        while (!done) @(posedge clk);
        check_result(c);
        if (busy_start) begin
            check_untouched(other.dst_addr, -GUARD,
                            (int'(other.mat_width) + 2) ** 2 + GUARD - 1);
            repeat (20) @(posedge clk);
            check_value("done_o", done, 1'b1);   // No second job started
            check_value("ar bursts", u_mem.ar_log.size(), n + 2);
        end
        if (errors == errors_before) begin
            $display("test %0d width %0d: passed", id, n);
        end else begin
            failed_tests++;
            $display("test %0d width %0d: failed", id, n);
        end
    endtask

    initial begin
        int id;
        void'($urandom(9));
        rst_n        = 1'b0;
        start        = 1'b0;
        cfg          = '0;
        errors       = 0;
        failed_tests = 0;
        limit_set    = 1'b0;
        widths[0]    = 1;
        for (id = 1; id < NUM_TESTS; id++) begin
            widths[id] = $urandom_range(2, 8);
        end
        limit_cycles = 16 + 2000;
        for (id = 0; id < NUM_TESTS; id++) begin
            limit_cycles += 40 * (widths[id] + 2) * (widths[id] + 2);
        end
        limit_set = 1'b1;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        check_value("done_o", done, 1'b1);   // Idle out of reset
        $display("reset check: %s", (errors == 0) ? "passed" : "failed");
        for (id = 0; id < NUM_TESTS; id++) begin
            run_job(id + 1, widths[id], id == NUM_TESTS - 1);
        end
        $display("tests %0d, failed %0d, mismatches %0d", NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* pad_dma.f */
logic/pad_dma_pkg.sv
logic/pad_word_fifo.sv
logic/pad_row_reader.sv
logic/pad_row_writer.sv
logic/pad_dma_top.sv
test/axi_mem_model.sv
test/pad_dma_tb.sv

/* Makefile */
# Verilator build of the padding DMA testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f pad_dma.f \
		--top-module pad_dma_tb -Mdir obj_dir -o pad_dma_sim

run: compile
	./obj_dir/pad_dma_sim | tee sim.log
	@if grep -q "RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
